// File: hdl/dma_pkg.sv
`default_nettype none

package dma_pkg;

	// register port offsets need a fifth bit so that 0x10 can be decoded as a miss
	localparam int AXIL_AW = 5;
	localparam logic [31:0] DESC_STRIDE = 32'd12;

	typedef struct packed {
		logic        valid;
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic        last;
		logic [14:0] reserved;
		logic [15:0] count;
	} desc_ctrl_t;

	// word 0 sits in the low bits
	typedef struct packed {
		desc_ctrl_t  ctrl;
		logic [31:0] dst;
		logic [31:0] src;
	} desc_t;

	typedef struct packed {
		logic               awvalid;
		logic [AXIL_AW-1:0] awaddr;
		logic               wvalid;
		logic [31:0]        wdata;
		logic [3:0]         wstrb;
		logic               bready;
		logic               arvalid;
		logic [AXIL_AW-1:0] araddr;
		logic               rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	typedef enum logic [AXIL_AW-1:0] {
		REG_CTRL      = 5'h00,
		REG_DESC_ADDR = 5'h04,
		REG_STATUS    = 5'h08,
		REG_WORDS     = 5'h0C
	} csr_addr_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	typedef enum logic [1:0] {F_IDLE, F_WORD0, F_WORD1, F_WORD2} fetch_state_e;
	typedef enum logic [1:0] {C_IDLE, C_READ, C_WRITE} copy_state_e;
	typedef enum logic [1:0] {S_IDLE, S_FETCH, S_COPY, S_NEXT} ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/dma_csr.sv
`timescale 1ns/1ps
`default_nettype none

module dma_csr (
	input  wire               CLK,
	input  wire               reset,
	input  dma_pkg::axil_req_t axil_req,
	output dma_pkg::axil_rsp_t axil_rsp,
	output logic              start_pulse,
	output logic [31:0]       desc_base,
	input  wire               busy,
	input  wire               done_pulse,
	input  wire  [15:0]       desc_count,
	input  wire  [31:0]       word_count
);

	logic                        aw_seen;
	logic                        w_seen;
	logic [dma_pkg::AXIL_AW-1:0] aw_addr;
	logic [31:0]                 w_data;
	logic                        bvalid;
	dma_pkg::axi_resp_e          bresp;
	logic                        rvalid;
	logic [31:0]                 rdata;
	dma_pkg::axi_resp_e          rresp;
	logic                        done;
	logic                        wr_go;
	logic                        start_go;

	assign wr_go = aw_seen && w_seen;
	// a start while busy is answered but has no effect
	assign start_go = wr_go && (aw_addr == dma_pkg::REG_CTRL) && w_data[0]
		&& !busy && !start_pulse;

	always_comb begin
		axil_rsp         = '0;
		axil_rsp.awready = !aw_seen && !bvalid;
		axil_rsp.wready  = !w_seen && !bvalid;
		axil_rsp.bvalid  = bvalid;
		axil_rsp.bresp   = bresp;
		axil_rsp.arready = !rvalid;
		axil_rsp.rvalid  = rvalid;
		axil_rsp.rdata   = rdata;
		axil_rsp.rresp   = rresp;
	end

	// write side, AW and W land in any order
	always_ff @(posedge CLK) begin
		if (reset) begin
			aw_seen     <= 1'b0;
			w_seen      <= 1'b0;
			bvalid      <= 1'b0;
			bresp       <= dma_pkg::RESP_OKAY;
			start_pulse <= 1'b0;
			desc_base   <= '0;
			done        <= 1'b0;
		end else begin
			start_pulse <= start_go;
			if (axil_req.awvalid && axil_rsp.awready) begin
				aw_seen <= 1'b1;
				aw_addr <= axil_req.awaddr;
			end
			if (axil_req.wvalid && axil_rsp.wready) begin
				w_seen <= 1'b1;
				w_data <= axil_req.wdata;
			end
			if (wr_go) begin
				aw_seen <= 1'b0;
				w_seen  <= 1'b0;
				bvalid  <= 1'b1;
				case (dma_pkg::csr_addr_e'(aw_addr))
					dma_pkg::REG_CTRL:      bresp <= dma_pkg::RESP_OKAY;
					dma_pkg::REG_DESC_ADDR: begin
						desc_base <= w_data;
						bresp     <= dma_pkg::RESP_OKAY;
					end
					dma_pkg::REG_STATUS,
					dma_pkg::REG_WORDS:     bresp <= dma_pkg::RESP_OKAY; // read only
					default:                bresp <= dma_pkg::RESP_SLVERR;
				endcase
			end else if (bvalid && axil_req.bready) begin
				bvalid <= 1'b0;
			end
			if (start_go)
				done <= 1'b0;
			else if (done_pulse)
				done <= 1'b1; // sticky until next start
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			rvalid <= 1'b0;
			rdata  <= '0;
			rresp  <= dma_pkg::RESP_OKAY;
		end else if (axil_req.arvalid && axil_rsp.arready) begin
			rvalid <= 1'b1;
			rresp  <= dma_pkg::RESP_OKAY;
			case (dma_pkg::csr_addr_e'(axil_req.araddr))
				dma_pkg::REG_CTRL:      rdata <= '0;
				dma_pkg::REG_DESC_ADDR: rdata <= desc_base;
				dma_pkg::REG_STATUS:    rdata <= {desc_count, 14'd0, done, busy};
				dma_pkg::REG_WORDS:     rdata <= word_count;
				default: begin
					rdata <= '0;
					rresp <= dma_pkg::RESP_SLVERR;
				end
			endcase
		end else if (rvalid && axil_req.rready) begin
			rvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hdl/desc_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module desc_fetch (
	input  wire                CLK,
	input  wire                reset,
	input  wire                fetch_start,
	input  wire  [31:0]        fetch_addr,
	output dma_pkg::mem_req_t  mem_req,
	input  dma_pkg::mem_rsp_t  mem_rsp,
	output dma_pkg::desc_t     desc,
	output logic               desc_valid
);

	dma_pkg::fetch_state_e state;
	logic                  xfer;

	assign xfer = mem_req.valid && mem_rsp.ready;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state      <= dma_pkg::F_IDLE;
			mem_req    <= '0;
			desc_valid <= 1'b0;
		end else begin
			desc_valid <= 1'b0;
			case (state)
				dma_pkg::F_IDLE: begin
					if (fetch_start) begin
						state         <= dma_pkg::F_WORD0;
						mem_req.valid <= 1'b1;
						mem_req.write <= 1'b0;
						mem_req.addr  <= fetch_addr; // base latched here
						mem_req.wdata <= '0;
					end
				end
				dma_pkg::F_WORD0: begin
					if (xfer) begin
						state        <= dma_pkg::F_WORD1;
						mem_req.addr <= mem_req.addr + 32'd4;
					end
				end
				dma_pkg::F_WORD1: begin
					if (xfer) begin
						state        <= dma_pkg::F_WORD2;
						mem_req.addr <= mem_req.addr + 32'd4;
					end
				end
				dma_pkg::F_WORD2: begin
					if (xfer) begin
						state         <= dma_pkg::F_IDLE;
						mem_req.valid <= 1'b0;
						desc_valid    <= 1'b1; // third word in
					end
				end
				default: state <= dma_pkg::F_IDLE;
			endcase
		end
	end

	// descriptor words, captured as each read completes
	always_ff @(posedge CLK) begin
		if (xfer) begin
			case (state)
				dma_pkg::F_WORD0: desc.src  <= mem_rsp.rdata;
				dma_pkg::F_WORD1: desc.dst  <= mem_rsp.rdata;
				dma_pkg::F_WORD2: desc.ctrl <= mem_rsp.rdata;
				default:          desc      <= desc;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/copy_engine.sv
`timescale 1ns/1ps
`default_nettype none

module copy_engine #(
	parameter int COUNT_W = 16
) (
	input  wire                CLK,
	input  wire                reset,
	input  wire                copy_start,
	input  wire  [31:0]        src,
	input  wire  [31:0]        dst,
	input  wire  [COUNT_W-1:0] count,
	output dma_pkg::mem_req_t  mem_req,
	input  dma_pkg::mem_rsp_t  mem_rsp,
	output logic               copy_done,
	output logic               word_pulse
);

	dma_pkg::copy_state_e state;
	logic [31:0]          src_q;
	logic [31:0]          dst_q;
	logic [COUNT_W-1:0]   remain;
	logic                 xfer;

	assign xfer = mem_req.valid && mem_rsp.ready;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state      <= dma_pkg::C_IDLE;
			mem_req    <= '0;
			copy_done  <= 1'b0;
			word_pulse <= 1'b0;
			src_q      <= '0;
			dst_q      <= '0;
			remain     <= '0;
		end else begin
			copy_done  <= 1'b0;
			word_pulse <= 1'b0;
			case (state)
				dma_pkg::C_IDLE: begin
					if (copy_start) begin
						src_q  <= src;
						dst_q  <= dst;
						remain <= count;
						if (count == '0) begin
							copy_done <= 1'b1; // nothing to move
						end else begin
							state   <= dma_pkg::C_READ;
							mem_req <= {1'b1, 1'b0, src, 32'd0};
						end
					end
				end
				dma_pkg::C_READ: begin
					if (xfer) begin
						// read data rides along as write data
						state   <= dma_pkg::C_WRITE;
						mem_req <= {1'b1, 1'b1, dst_q, mem_rsp.rdata};
					end
				end
				dma_pkg::C_WRITE: begin
					if (xfer) begin
						word_pulse <= 1'b1;
						remain     <= remain - 1'b1;
						src_q      <= src_q + 32'd4;
						dst_q      <= dst_q + 32'd4;
						if (remain == COUNT_W'(1)) begin
							state         <= dma_pkg::C_IDLE;
							mem_req.valid <= 1'b0;
							copy_done     <= 1'b1;
						end else begin
							state   <= dma_pkg::C_READ;
							mem_req <= {1'b1, 1'b0, src_q + 32'd4, 32'd0};
						end
					end
				end
				default: state <= dma_pkg::C_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/dma_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl #(
	parameter int COUNT_W = 16
) (
	input  wire                CLK,
	input  wire                reset,
	input  wire                start_pulse,
	input  wire  [31:0]        desc_base,
	output logic               busy,
	output logic               done_pulse,
	output logic               irq,
	output logic [15:0]        desc_count,
	output logic [31:0]        word_count,
	output logic               fetch_start,
	output logic [31:0]        fetch_addr,
	input  dma_pkg::desc_t     desc,
	input  wire                desc_valid,
	output logic               copy_start,
	output logic [31:0]        src,
	output logic [31:0]        dst,
	output logic [COUNT_W-1:0] count,
	input  wire                copy_done,
	input  wire                word_pulse,
	input  dma_pkg::mem_req_t  fetch_req,
	input  dma_pkg::mem_req_t  copy_req,
	output dma_pkg::mem_req_t  mem_req
);

	dma_pkg::ctrl_state_e state;
	logic                 last_q;

	assign irq = done_pulse;

	// port owner follows the chain state
	always_comb begin
		case (state)
			dma_pkg::S_FETCH: mem_req = fetch_req;
			dma_pkg::S_COPY:  mem_req = copy_req;
			default:          mem_req = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state       <= dma_pkg::S_IDLE;
			busy        <= 1'b0;
			done_pulse  <= 1'b0;
			fetch_start <= 1'b0;
			copy_start  <= 1'b0;
			fetch_addr  <= '0;
			desc_count  <= '0;
			word_count  <= '0;
		end else begin
			done_pulse  <= 1'b0;
			fetch_start <= 1'b0;
			copy_start  <= 1'b0;
			if (word_pulse)
				word_count <= word_count + 32'd1;
			case (state)
				dma_pkg::S_IDLE: begin
					if (start_pulse) begin
						state       <= dma_pkg::S_FETCH;
						busy        <= 1'b1;
						fetch_addr  <= desc_base;
						fetch_start <= 1'b1;
						desc_count  <= '0;
						word_count  <= '0;
					end
				end
				dma_pkg::S_FETCH: begin
					if (desc_valid) begin
						state      <= dma_pkg::S_COPY;
						copy_start <= 1'b1;
					end
				end
				dma_pkg::S_COPY: begin
					if (copy_done) begin
						desc_count <= desc_count + 16'd1;
						if (last_q) begin
							state      <= dma_pkg::S_IDLE;
							busy       <= 1'b0;
							done_pulse <= 1'b1;
						end else begin
							state      <= dma_pkg::S_NEXT;
							fetch_addr <= fetch_addr + dma_pkg::DESC_STRIDE;
						end
					end
				end
				dma_pkg::S_NEXT: begin
					state       <= dma_pkg::S_FETCH;
					fetch_start <= 1'b1;
				end
				default: state <= dma_pkg::S_IDLE;
			endcase
		end
	end

	// copy job, held for the copier while it runs
	always_ff @(posedge CLK) begin
		if (desc_valid) begin
			src    <= desc.src;
			dst    <= desc.dst;
			count  <= desc.ctrl.count[COUNT_W-1:0];
			last_q <= desc.ctrl.last;
		end
	end

endmodule

`default_nettype wire

// File: hdl/dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_top #(
	parameter int COUNT_W = 16
) (
	input  wire                 CLK,
	input  wire                 reset,
	input  dma_pkg::axil_req_t  axil_req,
	output dma_pkg::axil_rsp_t  axil_rsp,
	output dma_pkg::mem_req_t   mem_req,
	input  dma_pkg::mem_rsp_t   mem_rsp,
	output logic                irq
);

	logic               start_pulse;
	logic [31:0]        desc_base;
	logic               busy;
	logic               done_pulse;
	logic [15:0]        desc_count;
	logic [31:0]        word_count;
	logic               fetch_start;
	logic [31:0]        fetch_addr;
	dma_pkg::desc_t     desc;
	logic               desc_valid;
	logic               copy_start;
	logic [31:0]        src;
	logic [31:0]        dst;
	logic [COUNT_W-1:0] count;
	logic               copy_done;
	logic               word_pulse;
	dma_pkg::mem_req_t  fetch_req;
	dma_pkg::mem_req_t  copy_req;

	dma_csr u_csr (
		.CLK(CLK), .reset(reset), .axil_req(axil_req), .axil_rsp(axil_rsp),
		.start_pulse(start_pulse), .desc_base(desc_base), .busy(busy),
		.done_pulse(done_pulse), .desc_count(desc_count), .word_count(word_count)
	);

	dma_ctrl #(.COUNT_W(COUNT_W)) u_ctrl (
		.CLK(CLK), .reset(reset), .start_pulse(start_pulse), .desc_base(desc_base),
		.busy(busy), .done_pulse(done_pulse), .irq(irq), .desc_count(desc_count),
		.word_count(word_count), .fetch_start(fetch_start), .fetch_addr(fetch_addr),
		.desc(desc), .desc_valid(desc_valid), .copy_start(copy_start), .src(src),
		.dst(dst), .count(count), .copy_done(copy_done), .word_pulse(word_pulse),
		.fetch_req(fetch_req), .copy_req(copy_req), .mem_req(mem_req)
	);

	desc_fetch u_fetch (
		.CLK(CLK), .reset(reset), .fetch_start(fetch_start), .fetch_addr(fetch_addr),
		.mem_req(fetch_req), .mem_rsp(mem_rsp), .desc(desc), .desc_valid(desc_valid)
	);

	copy_engine #(.COUNT_W(COUNT_W)) u_copy (
		.CLK(CLK), .reset(reset), .copy_start(copy_start), .src(src), .dst(dst),
		.count(count), .mem_req(copy_req), .mem_rsp(mem_rsp), .copy_done(copy_done),
		.word_pulse(word_pulse)
	);

endmodule

`default_nettype wire

// File: verification/dma_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dma_checker (
	input wire                    CLK,
	input wire                    reset,
	input wire dma_pkg::mem_req_t mem_req,
	input wire dma_pkg::mem_rsp_t mem_rsp,
	input wire                    irq,
	input wire                    busy
);

	int fail_count = 0;

	// a stalled request must not move
	req_stable: assert property (@(posedge CLK) disable iff (reset)
		mem_req.valid && !mem_rsp.ready |=> mem_req.valid && $stable(mem_req.write)
			&& $stable(mem_req.addr) && $stable(mem_req.wdata))
		else begin
			$error("memory request changed before ready");
			fail_count++;
		end

	irq_single: assert property (@(posedge CLK) disable iff (reset) irq |=> !irq)
		else begin
			$error("irq high for two cycles");
			fail_count++;
		end

	req_only_busy: assert property (@(posedge CLK) disable iff (reset) mem_req.valid |-> busy)
		else begin
			$error("memory request while not busy");
			fail_count++;
		end

endmodule

`default_nettype wire

// File: verification/dma_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dma_tb;

	localparam int PERIOD_NS   = 40;
	localparam int MEM_WORDS   = 1024;
	localparam int TOTAL_WORDS = 45; // words copied over all tests
	localparam int TOTAL_DESC  = 12;
	localparam int WORST_WAIT  = 5;  // cycles per memory transfer at most
	localparam int BUS_SLACK   = 800;
	localparam int WATCHDOG_NS = ((TOTAL_WORDS * 2 + TOTAL_DESC * 3) * WORST_WAIT + BUS_SLACK)
		* PERIOD_NS;

	logic               CLK;
	logic               reset;
	dma_pkg::axil_req_t axil_req;
	dma_pkg::axil_rsp_t axil_rsp;
	dma_pkg::mem_req_t  mem_req;
	dma_pkg::mem_rsp_t  mem_rsp;
	logic               irq;

	logic [31:0] mem     [MEM_WORDS];
	logic [31:0] exp_mem [MEM_WORDS];
	logic [31:0] mem_rng;
	logic [31:0] bus_rng;
	logic        rand_mode;
	int          wait_left;
	int          irq_count;
	int          irq_mark;

	dma_top #(.COUNT_W(16)) DUT (
		.CLK(CLK), .reset(reset), .axil_req(axil_req), .axil_rsp(axil_rsp),
		.mem_req(mem_req), .mem_rsp(mem_rsp), .irq(irq)
	);

	bind dma_top dma_checker u_checker (
		.CLK(CLK), .reset(reset), .mem_req(mem_req), .mem_rsp(mem_rsp),
		.irq(irq), .busy(busy)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			report_failure($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
	endtask

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	initial begin
		#(WATCHDOG_NS);
		report_failure($sformatf("timeout: tests still running after %0d ns", WATCHDOG_NS));
	end

	// memory model answering on the falling edge
	initial begin
		mem_rsp   = '0;
		wait_left = 0;
		mem_rng   = 32'd215;
		forever begin
			@(negedge CLK);
			mem_rsp = '0;
			if (mem_req.valid) begin
				if (mem_req.addr[1:0] != 2'b00 || mem_req.addr >= 32'(MEM_WORDS * 4))
					report_failure("memory request outside the model or not word aligned");
				if (wait_left == 0) begin
					mem_rsp.ready = 1'b1;
					if (mem_req.write)
						mem[mem_req.addr[11:2]] = mem_req.wdata;
					else
						mem_rsp.rdata = mem[mem_req.addr[11:2]];
					mem_rng   = xorshift32(mem_rng);
					wait_left = rand_mode ? int'(mem_rng % 32'd4) : 0;
				end else begin
					wait_left = wait_left - 1;
				end
			end
		end
	end

	initial begin
		irq_count = 0;
		forever begin
			@(negedge CLK);
			if (irq)
				irq_count++;
		end
	end

	task automatic bus_delay();
		int n;
		n = 0;
		if (rand_mode) begin
			bus_rng = xorshift32(bus_rng);
			n       = int'(bus_rng % 32'd4);
		end
		repeat (n) @(negedge CLK);
	endtask

	task automatic axil_write(input logic [dma_pkg::AXIL_AW-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		logic aw_hit;
		logic w_hit;
		@(negedge CLK);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr  = addr;
		axil_req.wvalid  = 1'b1;
		axil_req.wdata   = data;
		axil_req.wstrb   = 4'hF;
		while (axil_req.awvalid || axil_req.wvalid) begin
			aw_hit = axil_req.awvalid && axil_rsp.awready;
			w_hit  = axil_req.wvalid && axil_rsp.wready;
			@(negedge CLK);
			if (aw_hit)
				axil_req.awvalid = 1'b0;
			if (w_hit)
				axil_req.wvalid = 1'b0;
		end
		while (!axil_rsp.bvalid)
			@(negedge CLK);
		bus_delay();
		axil_req.bready = 1'b1;
		resp            = axil_rsp.bresp; // still held until the next edge
		@(negedge CLK);
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [dma_pkg::AXIL_AW-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		logic ar_hit;
		@(negedge CLK);
		axil_req.arvalid = 1'b1;
		axil_req.araddr  = addr;
		ar_hit           = 1'b0;
		while (!ar_hit) begin
			ar_hit = axil_rsp.arready;
			@(negedge CLK);
		end
		axil_req.arvalid = 1'b0;
		while (!axil_rsp.rvalid)
			@(negedge CLK);
		bus_delay();
		axil_req.rready = 1'b1;
		data            = axil_rsp.rdata;
		resp            = axil_rsp.rresp;
		@(negedge CLK);
		axil_req.rready = 1'b0;
	endtask

	task automatic mem_fill();
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i]     = 32'hC0DE_0000 ^ (32'(i) * 32'h9E37_79B9);
			exp_mem[i] = mem[i];
		end
	endtask

	// writes one descriptor and the copy it should cause into the expected image
	task automatic put_desc(input logic [31:0] addr, input logic [31:0] src,
			input logic [31:0] dst, input logic [15:0] count, input logic last);
		int d;
		int s;
		int t;
		d = int'(addr[11:2]);
		s = int'(src[11:2]);
		t = int'(dst[11:2]);
		mem[d]         = src;
		mem[d + 1]     = dst;
		mem[d + 2]     = {last, 15'd0, count};
		exp_mem[d]     = mem[d];
		exp_mem[d + 1] = mem[d + 1];
		exp_mem[d + 2] = mem[d + 2];
		for (int k = 0; k < int'(count); k++)
			exp_mem[t + k] = exp_mem[s + k];
	endtask

	task automatic put_chain3();
		put_desc(32'h100, 32'h400, 32'h800, 16'd3, 1'b0);
		put_desc(32'h10C, 32'h500, 32'h900, 16'd7, 1'b0);
		put_desc(32'h118, 32'h600, 32'hA00, 16'd2, 1'b1);
	endtask

	task automatic check_mem();
		for (int i = 0; i < MEM_WORDS; i++)
			check_eq($sformatf("mem[0x%03h]", i * 4), mem[i], exp_mem[i]);
	endtask

	task automatic start_chain(input logic [31:0] base);
		logic [1:0] resp;
		irq_mark = irq_count;
		axil_write(dma_pkg::REG_DESC_ADDR, base, resp);
		check_eq("bresp", 32'(resp), 32'(dma_pkg::RESP_OKAY));
		axil_write(dma_pkg::REG_CTRL, 32'd1, resp);
		check_eq("bresp", 32'(resp), 32'(dma_pkg::RESP_OKAY));
	endtask

	task automatic finish_chain(input logic [15:0] n_desc, input logic [31:0] n_words);
		logic [31:0] rdata;
		logic [1:0]  resp;
		while (irq_count == irq_mark)
			@(negedge CLK);
		repeat (4) @(negedge CLK); // room for a stray second pulse
		check_eq("irq_count", 32'(irq_count - irq_mark), 32'd1);
		axil_read(dma_pkg::REG_STATUS, rdata, resp);
		check_eq("rresp", 32'(resp), 32'(dma_pkg::RESP_OKAY));
		check_eq("status", rdata, {n_desc, 14'd0, 1'b1, 1'b0});
		axil_read(dma_pkg::REG_WORDS, rdata, resp);
		check_eq("words", rdata, n_words);
		check_mem();
	endtask

	task automatic test_single();
		mem_fill();
		put_desc(32'h100, 32'h400, 32'h800, 16'd5, 1'b1);
		start_chain(32'h100);
		finish_chain(16'd1, 32'd5);
	endtask

	task automatic test_chain(input logic random_waits);
		rand_mode = random_waits;
		mem_fill();
		put_chain3();
		start_chain(32'h100);
		finish_chain(16'd3, 32'd12);
		rand_mode = 1'b0;
	endtask

	task automatic test_zero_count();
		mem_fill();
		put_desc(32'h200, 32'h400, 32'h800, 16'd0, 1'b0);
		put_desc(32'h20C, 32'h440, 32'h840, 16'd4, 1'b1);
		start_chain(32'h200);
		finish_chain(16'd2, 32'd4);
	endtask

	task automatic test_registers();
		logic [31:0] rdata;
		logic [1:0]  resp;
		axil_write(dma_pkg::REG_DESC_ADDR, 32'hCAFE_0F00, resp);
		axil_read(dma_pkg::REG_DESC_ADDR, rdata, resp);
		check_eq("desc_addr", rdata, 32'hCAFE_0F00);
		axil_write(5'h10, 32'h1234_5678, resp);
		check_eq("bresp", 32'(resp), 32'(dma_pkg::RESP_SLVERR));
		axil_read(5'h10, rdata, resp);
		check_eq("rresp", 32'(resp), 32'(dma_pkg::RESP_SLVERR));
		// second start lands while the chain runs
		mem_fill();
		put_chain3();
		start_chain(32'h100);
		axil_read(dma_pkg::REG_STATUS, rdata, resp);
		check_eq("status.busy", 32'(rdata[1:0]), 32'd1);
		// a restart from here would skip the first descriptor
		axil_write(dma_pkg::REG_DESC_ADDR, 32'h10C, resp);
		axil_write(dma_pkg::REG_CTRL, 32'd1, resp);
		check_eq("bresp", 32'(resp), 32'(dma_pkg::RESP_OKAY));
		finish_chain(16'd3, 32'd12);
	endtask

	initial begin
		reset     = 1'b1;
		axil_req  = '0;
		rand_mode = 1'b0;
		bus_rng   = 32'd215;
		irq_mark  = 0;
		repeat (8) @(negedge CLK);
		reset = 1'b0;
		test_single();
		test_chain(1'b0);
		test_chain(1'b1);
		test_zero_count();
		test_registers();
		if (DUT.u_checker.fail_count == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			report_failure("assertion failures seen on the memory port or irq");
		end
	end

endmodule

`default_nettype wire

// File: sim.f
hdl/dma_pkg.sv
hdl/dma_csr.sv
hdl/desc_fetch.sv
hdl/copy_engine.sv
hdl/dma_ctrl.sv
hdl/dma_top.sv
verification/dma_checker.sv
verification/dma_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dma_tb -f sim.f -o dma_tb_sim

./obj_dir/dma_tb_sim | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
